// ==== design/width_convert_config.svh ====
/* width_convert_config
   word widths and frame geometry for the 16 to 24 bit stream converter */
`ifndef WIDTH_CONVERT_CONFIG_SVH
`define WIDTH_CONVERT_CONFIG_SVH

// input side word width
`define WC_ISIZE 16

// output side word width
`define WC_OSIZE 24

// lcm of the two widths, one frame holds a whole number of both
`define WC_FRAME_BITS 48

// words per frame on each side
`define WC_IN_PER_FRAME 3   // 48 / 16
`define WC_OUT_PER_FRAME 2  // 48 / 24

`endif

// ==== design/width_convert_pkg.sv ====
/* width_convert_pkg
   beat and frame types shared by the converter blocks and the testbench */
`include "width_convert_config.svh"

package width_convert_pkg;

    // one word on the 16 bit side
    typedef struct packed {
        logic [`WC_ISIZE-1:0] data;
        logic                 last;   // final word of a packet
    } in_beat_t;

    // one word on the 24 bit side
    typedef struct packed {
        logic [`WC_OSIZE-1:0] data;
        logic                 last;
    } out_beat_t;

    // gathered frame between gather and scatter
    // data holds input words low slot first, unused slots are zero
    typedef struct packed {
        logic [`WC_FRAME_BITS-1:0]              data;
        logic [$clog2(`WC_IN_PER_FRAME+1)-1:0] fill;   // input words held, 1..3
        logic                                   last;   // frame closes a packet
    } frame_t;

endpackage

// ==== design/stream_skid_buffer.sv ====
/* stream_skid_buffer
   two entry valid/ready buffer with registered ready, payload type is a parameter */
`timescale 1ns/10ps

module stream_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t in_payload,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_payload,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t main_q;          // beat presented downstream
    payload_t skid_q;          // overflow beat while downstream stalls
    logic     main_valid;
    logic     skid_valid;
    logic     main_valid_d;
    logic     skid_valid_d;
    logic     load_main;       // main takes the incoming beat
    logic     load_skid;       // skid takes the incoming beat
    logic     main_from_skid;  // skid beat moves forward
    logic     in_fire;

    assign in_fire     = in_valid && in_ready;
    assign out_payload = main_q;
    assign out_valid   = main_valid;

    // next state of the two slots
    always_comb begin
        main_valid_d   = main_valid;
        skid_valid_d   = skid_valid;
        load_main      = 1'b0;
        load_skid      = 1'b0;
        main_from_skid = 1'b0;
        if (!main_valid || out_ready) begin
            // main slot empties or is being taken this cycle
            if (skid_valid) begin
                main_from_skid = 1'b1;   // older beat first, keeps order
                skid_valid_d   = 1'b0;
            end else begin
                main_valid_d = in_fire;
                load_main    = in_fire;
            end
        end else if (in_fire) begin
            // main stalled, park the new beat
            skid_valid_d = 1'b1;
            load_skid    = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            main_valid <= main_valid_d;
            skid_valid <= skid_valid_d;
            in_ready   <= !skid_valid_d;   // full once both slots hold a beat
        end
        // payload slots carry no reset
        if (load_main)
            main_q <= in_payload;
        else if (main_from_skid)
            main_q <= skid_q;
        if (load_skid)
            skid_q <= in_payload;
    end

    // downstream sees a steady beat until it takes it
    payload_hold_a: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_payload));

endmodule

// ==== design/word_gather.sv ====
/* word_gather
   packs 16 bit words into 48 bit frames, closing early on packet last */
`timescale 1ns/10ps
`include "width_convert_config.svh"

module word_gather (
    input  logic                        clock,
    input  logic                        reset,
    input  width_convert_pkg::in_beat_t in_beat,
    input  logic                        in_valid,
    output logic                        in_ready,
    output width_convert_pkg::frame_t   frame,
    output logic                        frame_valid,
    input  logic                        frame_ready
);

    import width_convert_pkg::*;

    frame_t acc;          // accumulator, fill counts words held
    frame_t merged;       // accumulator with the incoming word added
    logic   merged_done;  // incoming word closes the frame
    logic   acc_full;     // closed frame parked, frame register busy
    logic   frame_free;   // frame register can load this cycle
    logic   in_fire;

    assign in_ready   = !acc_full;   // state only, stall with a frame parked
    assign in_fire    = in_valid && in_ready;
    assign frame_free = !frame_valid || frame_ready;

    // slot placement, first word lands in the low bits
    always_comb begin
        merged = acc;
        for (int i = 0; i < `WC_IN_PER_FRAME; i++) begin
            if (i == acc.fill)
                merged.data[i*`WC_ISIZE +: `WC_ISIZE] = in_beat.data;
            else if (i > acc.fill)
                merged.data[i*`WC_ISIZE +: `WC_ISIZE] = '0;   // zero fill past the word
        end
        merged.fill = acc.fill + 1'b1;
        merged.last = in_beat.last;
        merged_done = (int'(merged.fill) == `WC_IN_PER_FRAME) || in_beat.last;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            acc.fill    <= '0;
            acc_full    <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            if (frame_valid && frame_ready)
                frame_valid <= 1'b0;   // taken by scatter
            if (acc_full && frame_free) begin
                // parked frame moves out, accumulator reopens
                frame_valid <= 1'b1;
                acc_full    <= 1'b0;
                acc.fill    <= '0;
            end else if (in_fire) begin
                if (merged_done && frame_free) begin
                    frame_valid <= 1'b1;   // straight to the frame register
                    acc.fill    <= '0;
                end else begin
                    acc.fill <= merged.fill;
                    acc_full <= merged_done;   // second frame waits here
                end
            end
        end
        // data and last of both registers have no reset
        if (acc_full && frame_free)
            frame <= acc;
        else if (in_fire && merged_done && frame_free)
            frame <= merged;
        if (in_fire) begin
            acc.data <= merged.data;
            acc.last <= merged.last;
        end
    end

    // open accumulator stays below a full frame, a presented frame holds at least one word
    fill_range_a: assert property (@(posedge clock) disable iff (reset)
        (acc_full || int'(acc.fill) < `WC_IN_PER_FRAME) &&
        (!frame_valid || frame.fill != '0));

endmodule

// ==== design/word_scatter.sv ====
/* word_scatter
   splits each 48 bit frame into 24 bit slices, low bits first, last on the final one */
`timescale 1ns/10ps
`include "width_convert_config.svh"

module word_scatter (
    input  logic                         clock,
    input  logic                         reset,
    input  width_convert_pkg::frame_t    frame,
    input  logic                         frame_valid,
    output logic                         frame_ready,
    output width_convert_pkg::out_beat_t out_beat,
    output logic                         out_valid,
    input  logic                         out_ready
);

    import width_convert_pkg::*;

    localparam int SLICE_W = $clog2(`WC_OUT_PER_FRAME);

    frame_t             hold;         // slice register, frame being sent
    logic               hold_valid;
    logic [SLICE_W-1:0] slice_idx;    // slice on the output now
    logic               final_slice;  // no packet bits beyond this slice
    logic               slice_fire;
    logic               frame_fire;

    // slice covers every held input bit once its top reaches fill * ISIZE
    // so fill 1 gives one slice and fills 2, 3 give two
    assign final_slice = (int'(slice_idx) + 1) * `WC_OSIZE >= int'(hold.fill) * `WC_ISIZE;

    assign out_valid     = hold_valid;
    assign out_beat.data = hold.data[slice_idx*`WC_OSIZE +: `WC_OSIZE];
    assign out_beat.last = hold.last && final_slice;   // only the closing slice of a packet
    assign slice_fire    = out_valid && out_ready;

    // free when empty or when the last slice leaves this cycle
    assign frame_ready = !hold_valid || (out_ready && final_slice);
    assign frame_fire  = frame_valid && frame_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            hold_valid <= 1'b0;
            slice_idx  <= '0;
        end else begin
            if (frame_fire) begin
                hold_valid <= 1'b1;
                slice_idx  <= '0;   // slice 0 shows next cycle
            end else if (slice_fire) begin
                if (final_slice)
                    hold_valid <= 1'b0;
                else
                    slice_idx <= slice_idx + 1'b1;
            end
        end
        if (frame_fire)
            hold <= frame;   // frame payload, no reset
    end

    // after a last slice goes out, anything next starts a fresh frame at slice 0
    last_is_final_a: assert property (@(posedge clock) disable iff (reset)
        slice_fire && out_beat.last |=> !out_valid || slice_idx == '0);

endmodule

// ==== design/odd_width_convert.sv ====
/* odd_width_convert
   16 to 24 bit packet stream converter, buffer, gather, scatter, buffer */
`timescale 1ns/10ps
`include "width_convert_config.svh"

module odd_width_convert (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [`WC_ISIZE-1:0] in_data,
    input  logic                 in_valid,
    input  logic                 in_last,
    output logic                 in_ready,
    output logic [`WC_OSIZE-1:0] out_data,
    output logic                 out_valid,
    output logic                 out_last,
    input  logic                 out_ready
);

    import width_convert_pkg::*;

    in_beat_t  in_beat;        // packed input port bits
    in_beat_t  buf_beat;       // input buffer to gather
    logic      buf_valid;
    logic      buf_ready;
    frame_t    frame;          // gather to scatter
    logic      frame_valid;
    logic      frame_ready;
    out_beat_t scat_beat;      // scatter to output buffer
    logic      scat_valid;
    logic      scat_ready;
    out_beat_t out_beat;       // output buffer to ports

    assign in_beat.data = in_data;
    assign in_beat.last = in_last;

    stream_skid_buffer #(.payload_t(in_beat_t)) in_buf (
        .clock       (clock),
        .reset       (reset),
        .in_payload  (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),     // registered, decouples the source
        .out_payload (buf_beat),
        .out_valid   (buf_valid),
        .out_ready   (buf_ready)
    );

    word_gather gather (
        .clock       (clock),
        .reset       (reset),
        .in_beat     (buf_beat),
        .in_valid    (buf_valid),
        .in_ready    (buf_ready),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready)
    );

    word_scatter scatter (
        .clock       (clock),
        .reset       (reset),
        .frame       (frame),
        .frame_valid (frame_valid),
        .frame_ready (frame_ready),
        .out_beat    (scat_beat),
        .out_valid   (scat_valid),
        .out_ready   (scat_ready)
    );

    stream_skid_buffer #(.payload_t(out_beat_t)) out_buf (
        .clock       (clock),
        .reset       (reset),
        .in_payload  (scat_beat),
        .in_valid    (scat_valid),
        .in_ready    (scat_ready),
        .out_payload (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)     // sink back-pressure stops here
    );

    assign out_data = out_beat.data;
    assign out_last = out_beat.last;

endmodule

// ==== sim/odd_width_convert_tb.sv ====
/* odd_width_convert_tb
   table driven testbench, packs each packet with a reference bit packer and scores the output */
`timescale 1ns/10ps
`include "width_convert_config.svh"

module odd_width_convert_tb;

    import width_convert_pkg::*;

    localparam int CLK_HALF        = 4;     // 8 ns clock
    localparam int RESET_CYCLES    = 4;
    localparam int CYCLES_PER_WORD = 20;    // watchdog budget per input word
    localparam int WATCHDOG_MARGIN = 200;   // reset, pipeline fill and drain
    localparam int DRAIN_CYCLES    = 12;
    localparam int NUM_TESTS       = 15;

    // stimulus table, one row per packet, sent back to back
    // columns are name, packet length in input words, out_ready stall percent
    string test_name [NUM_TESTS] = '{
        "mult3_len3",  "mult3_len6",  "mult3_len12", "short_len1",    "short_len2",
        "short_len4",  "short_len5",  "mixed_len7",  "mixed_len1",    "mixed_len8",
        "stall30_len10", "stall50_len11", "stall70_len9", "stall70_len1", "stall70_len14"};
    int test_len [NUM_TESTS] = '{
        3,  6,  12, 1,  2,
        4,  5,  7,  1,  8,
        10, 11, 9,  1,  14};
    int test_stall [NUM_TESTS] = '{
        0,  0,  0,  0,  0,
        0,  0,  0,  0,  0,
        30, 50, 70, 70, 70};

    logic                 clock = 1'b0;
    logic                 reset;
    logic [`WC_ISIZE-1:0] in_data;
    logic                 in_valid;
    logic                 in_last;
    logic                 in_ready;
    logic [`WC_OSIZE-1:0] out_data;
    logic                 out_valid;
    logic                 out_last;
    logic                 out_ready;

    logic [31:0]          lcg_state;        // shared random state, one process uses it
    logic [`WC_ISIZE-1:0] stim_data [$];    // every input word of the run, in order
    logic                 stim_last [$];
    out_beat_t            exp_beat [$];     // expected output words with last
    int                   exp_row [$];      // table row of each expected word
    int                   expected_total;   // ceil(16N/24) summed over the table
    int                   out_count;        // output words seen so far
    int                   idx;              // next input word to offer
    int                   cur_row;

    odd_width_convert UUT (
        .clock     (clock),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    always #CLK_HALF clock = ~clock;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
    endfunction

    function automatic int table_word_count();
        int total;
        total = 0;
        for (int r = 0; r < NUM_TESTS; r++)
            total += test_len[r];
        return total;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // packet as one bit stream, first word lowest, cut into 24 bit words
    task automatic pack_packet(input int row, input int first, input int len);
        logic [63:0] bits;
        int          nbits;
        int          nout;
        int          k;
        out_beat_t   beat;
        bits  = '0;
        nbits = 0;
        k     = 0;
        nout  = (len * `WC_ISIZE + `WC_OSIZE - 1) / `WC_OSIZE;   // output length rule
        for (int i = 0; i < len; i++) begin
            bits  = bits | (64'(stim_data[first + i]) << nbits);
            nbits += `WC_ISIZE;
            // full words go out, the tail goes out zero padded
            while (nbits >= `WC_OSIZE || (i == len - 1 && nbits > 0)) begin
                beat.data = bits[`WC_OSIZE-1:0];
                beat.last = (k == nout - 1);
                exp_beat.push_back(beat);
                exp_row.push_back(row);
                bits  = bits >> `WC_OSIZE;
                nbits -= `WC_OSIZE;   // negative once the padding is used
                k++;
            end
        end
    endtask

    // random payload for every row, expected words built up front
    task automatic build_stimulus();
        int first;
        expected_total = 0;
        for (int r = 0; r < NUM_TESTS; r++) begin
            first = stim_data.size();
            for (int i = 0; i < test_len[r]; i++) begin
                lcg_state = lcg_step(lcg_state);
                stim_data.push_back(lcg_state[31:16]);   // upper bits, better spread
                stim_last.push_back(i == test_len[r] - 1);
            end
            pack_packet(r, first, test_len[r]);
            expected_total += (test_len[r] * `WC_ISIZE + `WC_OSIZE - 1) / `WC_OSIZE;
        end
    endtask

    task automatic check_output_word();
        assert (exp_beat.size() != 0) else
            abort_run("DUT sent an output word after the expected stream ended");
        assert ({out_data, out_last} === exp_beat[0]) else
            abort_run($sformatf("Fail %s: expected data %h last %b, actual data %h last %b",
                test_name[exp_row[0]], exp_beat[0].data, exp_beat[0].last,
                out_data, out_last));
        void'(exp_beat.pop_front());
        void'(exp_row.pop_front());
        out_count++;
    endtask

    initial begin
        reset     = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        out_count = 0;
        idx       = 0;
        cur_row   = 0;
        lcg_state = 32'h6a20_db42;
        build_stimulus();

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        assert (out_valid === 1'b0) else
            abort_run($sformatf("Fail reset_idle: expected out_valid 0, actual %b", out_valid));

        // one pass per cycle, inputs offered back to back with no idle cycles
        while (idx < stim_data.size() || exp_beat.size() != 0) begin
            @(posedge clock);
            if (in_valid && in_ready)
                idx++;                   // word taken at this edge
            if (out_valid && out_ready)
                check_output_word();
            cur_row = (exp_row.size() != 0) ? exp_row[0] : NUM_TESTS - 1;   // packet leaving now
            lcg_state = lcg_step(lcg_state);
            out_ready <= (int'(lcg_state[31:16]) % 100) >= test_stall[cur_row];
            if (idx < stim_data.size()) begin
                in_valid <= 1'b1;        // held with its payload until taken
                in_data  <= stim_data[idx];
                in_last  <= stim_last[idx];
            end else begin
                in_valid <= 1'b0;
                in_last  <= 1'b0;
            end
        end

        // nothing may follow the expected stream
        out_ready <= 1'b1;
        repeat (DRAIN_CYCLES) begin
            @(posedge clock);
            if (out_valid !== 1'b0)
                out_count++;             // surplus word, taken since out_ready is high
        end

        if (out_count == expected_total) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run($sformatf("Fail word_count: expected %0d, actual %0d",
                expected_total, out_count));
        end
    end

    // budget scales with the table length
    initial begin
        repeat (CYCLES_PER_WORD * table_word_count() + WATCHDOG_MARGIN) @(posedge clock);
        abort_run("Timeout: the output stream did not finish within the cycle budget");
    end

endmodule

// ==== flist.f ====
+incdir+design
design/width_convert_pkg.sv
design/stream_skid_buffer.sv
design/word_gather.sv
design/word_scatter.sv
design/odd_width_convert.sv
sim/odd_width_convert_tb.sv

// ==== Makefile ====
# Verilator flow for the 16 to 24 bit stream converter
# every variable can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= odd_width_convert_tb
DUT_TOP    ?= odd_width_convert
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert
WARN_FLAGS ?= -Wall -Wno-fatal
FAIL_MSG   ?= Simulation failed
PASS_MSG   ?= Simulation passed

SRCS := $(shell grep -v '^+' $(FLIST)) design/width_convert_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# lint the RTL top alone, then together with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(WARN_FLAGS) -f $(FLIST) --top-module $(DUT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) $(WARN_FLAGS) -f $(FLIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) $(WARN_FLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

# the log decides the result, a fatal exit still leaves its lines there
sim: $(BIN)
	-$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "sim: failure reported, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "sim: run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
